// File: project.f
source/serial_core_pkg.sv
source/core_state.sv
source/instr_decode.sv
source/imm_decode.sv
source/serial_alu.sv
source/pc_ctrl.sv
source/serial_core_top.sv
testbench/serial_core_checker.sv
testbench/serial_core_tb.sv

// File: testbench/serial_core_tb.sv
`timescale 1ns/1ps

module serial_core_tb
   import serial_core_pkg::*;
();

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
   localparam int NUM_TESTS  = 200;
   localparam int CLK_PERIOD = 4;
   localparam int TIMEOUT_NS = NUM_TESTS * 40 * CLK_PERIOD * 2;

   logic              clk;
   logic              rst_n;
   logic [XLEN-1:0]   ibus_rdt;
   logic              ibus_ack;
   logic              rs1_bit;
   logic              rs2_bit;
   logic [XLEN-1:0]   ibus_adr;
   logic              ibus_cyc;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic [REG_AW-1:0] rd_addr;
   logic [CNT_W-1:0]  rf_bit;
   logic              rd_wen;
   logic              rd_bit;

   logic [XLEN-1:0] regs [32];
   logic [XLEN-1:0] rnd;
   logic [XLEN-1:0] instr;
   logic [XLEN-1:0] model_pc;
   logic [XLEN-1:0] next_pc;
   logic [XLEN-1:0] exp_val;
   logic [XLEN-1:0] got_val;
   logic [XLEN-1:0] rs1_val;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] i_imm;
   logic [XLEN-1:0] j_imm;
   logic            kept;
   logic            exp_we;
   string           iname;
   int              errors;
   int              checks;
   int              err_start;
   int              wr_cnt;
   int              wait_cyc;
   int              delay;

   serial_core_top #(
      .RESET_PC (RESET_PC)
   ) serial_core_top_inst (
      .clk        (clk     ),
      .i_rst_n    (rst_n   ),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_rs1_bit  (rs1_bit ),
      .i_rs2_bit  (rs2_bit ),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr ),
      .o_rf_bit   (rf_bit  ),
      .o_rd_wen   (rd_wen  ),
      .o_rd_bit   (rd_bit  )
   );

   bind serial_core_top serial_core_checker checker_inst (
      .clk       (clk       ),
      .i_rst_n   (i_rst_n   ),
      .i_ack     (i_ibus_ack),
      .i_cyc     (o_ibus_cyc),
      .i_adr     (o_ibus_adr),
      .i_wen     (o_rd_wen  ),
      .i_rd_addr (o_rd_addr )
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Register file with combinational bit reads and one bit written per strobe
   assign rs1_bit = regs[rs1_addr][rf_bit];
   assign rs2_bit = regs[rs2_addr][rf_bit];

   always @(posedge clk) begin
      if (rd_wen) begin
         regs[rd_addr][rf_bit] <= rd_bit;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic make_instr();
      rnd = xorshift32(rnd);
      instr = xorshift32(rnd ^ 32'h5a5a_0f0f);
      kept = (rnd[2:0] <= 3'd5);
      case (rnd[4:3])
         2'd0:    instr[14:12] = 3'b000;
         2'd1:    instr[14:12] = 3'b100;
         2'd2:    instr[14:12] = 3'b110;
         default: instr[14:12] = 3'b111;
      endcase
      case (rnd[2:0])
         3'd0, 3'd1: begin
            instr[6:0]   = OPC_REG;
            instr[31:25] = (instr[14:12] == 3'b000 && rnd[5]) ? 7'b0100000 : 7'b0;
            iname = "reg";
         end
         3'd2, 3'd3: begin
            instr[6:0] = OPC_IMM;
            iname = "imm";
         end
         3'd4: begin
            instr[6:0] = OPC_LUI;
            iname = "lui";
         end
         3'd5: begin
            instr[6:0] = OPC_JAL;
            // Keep jump targets word aligned
            instr[21] = 1'b0;
            iname = "jal";
         end
         3'd6: begin
            instr[6:0]   = OPC_IMM;
            instr[14:12] = {1'b0, rnd[7:6] | 2'b01};
            iname = "nop";
         end
         default: begin
            instr[6:0] = 7'b0000011;
            iname = "nop";
         end
      endcase
      if (rnd[10:8] == 3'd0) begin
         instr[11:7] = '0;
      end
   endtask

   // Reference model after the RV32I rules
   task automatic predict();
      rs1_val = regs[instr[19:15]];
      i_imm = {{20{instr[31]}}, instr[31:20]};
      j_imm = '0;
      j_imm[10:1]  = instr[30:21];
      j_imm[11]    = instr[20];
      j_imm[19:12] = instr[19:12];
      j_imm[31:20] = {12{instr[31]}};
      op_b = (instr[6:0] == OPC_IMM) ? i_imm : regs[instr[24:20]];
      next_pc = model_pc + 32'd4;
      case (instr[14:12])
         3'b100:  exp_val = rs1_val ^ op_b;
         3'b110:  exp_val = rs1_val | op_b;
         3'b111:  exp_val = rs1_val & op_b;
         default: exp_val = (instr[6:0] == OPC_REG && instr[30]) ? rs1_val - op_b
                                                                  : rs1_val + op_b;
      endcase
      if (instr[6:0] == OPC_LUI) begin
         exp_val = {instr[31:12], 12'b0};
      end
      if (instr[6:0] == OPC_JAL) begin
         exp_val = model_pc + 32'd4;
         next_pc = model_pc + j_imm;
      end
      exp_we = kept && (instr[11:7] != 5'd0);
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not end within %0d ns", TIMEOUT_NS);
      $display("Errors found");
      $finish;
   end

   initial begin
      rst_n    = 1'b0;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      errors   = 0;
      checks   = 0;
      rnd      = 32'h9ad0b736;
      model_pc = RESET_PC;
      regs[0] <= '0;
      for (int i = 1; i < 32; i++) begin
         rnd = xorshift32(rnd);
         regs[i] <= rnd;
      end
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      compare("o_rd_wen", rd_wen, 0);
      for (int t = 0; t < NUM_TESTS; t++) begin
         err_start = errors;
         wait_cyc = 0;
         while (!ibus_cyc) begin
            @(posedge clk);
            #1;
            wait_cyc++;
         end
         compare("fetch_wait", wait_cyc, 0);
         make_instr();
         rnd = xorshift32(rnd);
         delay = rnd[1:0];
         repeat (delay) begin
            compare("o_ibus_adr", ibus_adr, model_pc);
            @(posedge clk);
            #1;
         end
         compare("o_ibus_adr", ibus_adr, model_pc);
         predict();
         ibus_ack = 1'b1;
         ibus_rdt = instr;
         @(posedge clk);
         #1;
         ibus_ack = 1'b0;
         ibus_rdt = '0;
         if (exp_we) begin
            compare("o_rd_addr", rd_addr, instr[11:7]);
         end
         if (instr[6:0] == OPC_REG || instr[6:0] == OPC_IMM) begin
            compare("o_rs1_addr", rs1_addr, instr[19:15]);
         end
         if (instr[6:0] == OPC_REG) begin
            compare("o_rs2_addr", rs2_addr, instr[24:20]);
         end
         wr_cnt  = 0;
         got_val = '0;
         for (int k = 0; k < XLEN; k++) begin
            compare("o_rf_bit", rf_bit, k);
            compare("o_rd_wen", rd_wen, exp_we);
            compare("o_ibus_cyc", ibus_cyc, 0);
            if (rd_wen) begin
               wr_cnt++;
               got_val[k] = rd_bit;
            end
            @(posedge clk);
            #1;
         end
         compare("write_cycles", wr_cnt, exp_we ? XLEN : 0);
         if (exp_we) begin
            compare("rd_value", got_val, exp_val);
         end
         compare("x0", regs[0], 0);
         $display("test %0d %s pc %h instr %h delay %0d: %s", t, iname, model_pc, instr,
                  delay, (errors == err_start) ? "ok" : "mismatch");
         model_pc = next_pc;
      end
      compare("o_ibus_adr", ibus_adr, model_pc);
      compare("checker_failures", serial_core_top_inst.checker_inst.fail_cnt, 0);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: testbench/serial_core_checker.sv
`timescale 1ns/1ps

module serial_core_checker
   import serial_core_pkg::*;
(
   input logic              clk,
   input logic              i_rst_n,
   input logic              i_ack,
   input logic              i_cyc,
   input logic [XLEN-1:0]   i_adr,
   input logic              i_wen,
   input logic [REG_AW-1:0] i_rd_addr
);

   int fail_cnt = 0;

   // Request and address hold until acknowledged
   a_bus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_cyc && !i_ack) |=> (i_cyc && $stable(i_adr)))
      else begin
         fail_cnt++;
         $error("ibus request or address changed before acknowledge");
      end

   a_fetch_no_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_cyc && i_wen))
      else begin
         fail_cnt++;
         $error("write strobe high during fetch");
      end

   // x0 is never a write target
   a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wen |-> (i_rd_addr != '0))
      else begin
         fail_cnt++;
         $error("write strobe high with rd equal to x0");
      end

endmodule

// File: source/serial_core_top.sv
`timescale 1ns/1ps

module serial_core_top
   import serial_core_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = '0
)
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   input  logic              i_ibus_ack,
   input  logic              i_rs1_bit,
   input  logic              i_rs2_bit,
   output logic [XLEN-1:0]   o_ibus_adr,
   output logic              o_ibus_cyc,
   output logic [REG_AW-1:0] o_rs1_addr,
   output logic [REG_AW-1:0] o_rs2_addr,
   output logic [REG_AW-1:0] o_rd_addr,
   output logic [CNT_W-1:0]  o_rf_bit,
   output logic              o_rd_wen,
   output logic              o_rd_bit
);

   logic     cnt_en;
   logic     cnt_done;
   logic     rd_we;
   alu_op_t  alu_op;
   logic     op_b_imm;
   imm_fmt_t imm_fmt;
   rd_src_t  rd_src;
   logic     jump;
   logic     imm_bit;
   logic     link_bit;

   core_state state (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_ibus_ack (i_ibus_ack),
      .i_rd_we    (rd_we     ),
      .o_ibus_cyc (o_ibus_cyc),
      .o_cnt_en   (cnt_en    ),
      .o_cnt_done (cnt_done  ),
      .o_rd_wen   (o_rd_wen  ),
      .o_cnt      (o_rf_bit  )
   );

   instr_decode decode (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_rs1_addr (o_rs1_addr),
      .o_rs2_addr (o_rs2_addr),
      .o_rd_addr  (o_rd_addr ),
      .o_alu_op   (alu_op    ),
      .o_op_b_imm (op_b_imm  ),
      .o_imm_fmt  (imm_fmt   ),
      .o_rd_src   (rd_src    ),
      .o_jump     (jump      ),
      .o_rd_we    (rd_we     )
   );

   imm_decode immdec (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_imm_fmt  (imm_fmt   ),
      .i_cnt_en   (cnt_en    ),
      .o_imm_bit  (imm_bit   )
   );

   serial_alu alu (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt_done (cnt_done  ),
      .i_rs1_bit  (i_rs1_bit ),
      .i_rs2_bit  (i_rs2_bit ),
      .i_imm_bit  (imm_bit   ),
      .i_link_bit (link_bit  ),
      .i_op_b_imm (op_b_imm  ),
      .i_alu_op   (alu_op    ),
      .i_rd_src   (rd_src    ),
      .o_rd_bit   (o_rd_bit  )
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt      (o_rf_bit  ),
      .i_jump     (jump      ),
      .i_imm_bit  (imm_bit   ),
      .o_ibus_adr (o_ibus_adr),
      .o_link_bit (link_bit  )
   );

endmodule

// File: source/pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl
   import serial_core_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = '0
)
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_cnt_en,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_jump,
   input  logic             i_imm_bit,
   output logic [XLEN-1:0]  o_ibus_adr,
   output logic             o_link_bit
);

   logic [XLEN-1:0] pc_q;
   logic            four_bit;
   logic            c4_q;
   logic            cj_q;
   logic            sum4;
   logic            sumj;
   logic            c4_out;
   logic            cj_out;
   logic            pc_new;

   // Only bit 2 of the constant 4 is set
   assign four_bit = (i_cnt == CNT_W'(2));

   assign sum4   = pc_q[0] ^ four_bit ^ c4_q;
   assign c4_out = (pc_q[0] & four_bit) | (c4_q & (pc_q[0] ^ four_bit));
   assign sumj   = pc_q[0] ^ i_imm_bit ^ cj_q;
   assign cj_out = (pc_q[0] & i_imm_bit) | (cj_q & (pc_q[0] ^ i_imm_bit));
   assign pc_new = i_jump ? sumj : sum4;

   // PC rotates through bit 0 during execute
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= RESET_PC;
         c4_q <= 1'b0;
         cj_q <= 1'b0;
      end else if (i_cnt_en) begin
         pc_q <= {pc_new, pc_q[XLEN-1:1]};
         c4_q <= c4_out;
         cj_q <= cj_out;
      end else begin
         c4_q <= 1'b0;
         cj_q <= 1'b0;
      end
   end

   assign o_ibus_adr = pc_q;
   assign o_link_bit = sum4;

endmodule

// File: source/serial_alu.sv
`timescale 1ns/1ps

module serial_alu
   import serial_core_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_cnt_en,
   input  logic    i_cnt_done,
   input  logic    i_rs1_bit,
   input  logic    i_rs2_bit,
   input  logic    i_imm_bit,
   input  logic    i_link_bit,
   input  logic    i_op_b_imm,
   input  alu_op_t i_alu_op,
   input  rd_src_t i_rd_src,
   output logic    o_rd_bit
);

   logic sub;
   logic op_b;
   logic b_inv;
   logic carry_q;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic result;

   assign sub   = (i_alu_op == ALU_SUB);
   assign op_b  = i_op_b_imm ? i_imm_bit : i_rs2_bit;
   assign b_inv = op_b ^ sub;

   // Carry kept inverted for sub so that it always restarts at zero
   assign carry_in  = carry_q ^ sub;
   assign sum       = i_rs1_bit ^ b_inv ^ carry_in;
   assign carry_out = (i_rs1_bit & b_inv) | (carry_in & (i_rs1_bit ^ b_inv));

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= i_cnt_done ? 1'b0 : (carry_out ^ sub);
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_AND: result = i_rs1_bit & op_b;
         ALU_OR:  result = i_rs1_bit | op_b;
         ALU_XOR: result = i_rs1_bit ^ op_b;
         default: result = sum;
      endcase
   end

   always_comb begin
      case (i_rd_src)
         RD_IMM:  o_rd_bit = i_imm_bit;
         RD_LINK: o_rd_bit = i_link_bit;
         default: o_rd_bit = result;
      endcase
   end

endmodule

// File: source/imm_decode.sv
`timescale 1ns/1ps

module imm_decode
   import serial_core_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_ibus_ack,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  imm_fmt_t        i_imm_fmt,
   input  logic            i_cnt_en,
   output logic            o_imm_bit
);

   logic [XLEN-1:0] imm_q;
   logic [XLEN-1:0] imm_fmt_val;
   logic [XLEN-1:0] imm_cur;
   logic            shifting_q;

   // Raw instruction word until the first execute cycle
   always_comb begin
      case (i_imm_fmt)
         IMM_U:   imm_fmt_val = {imm_q[31:12], 12'b0};
         IMM_J:   imm_fmt_val = {{12{imm_q[31]}}, imm_q[19:12], imm_q[20], imm_q[30:21], 1'b0};
         default: imm_fmt_val = {{20{imm_q[31]}}, imm_q[31:20]};
      endcase
   end

   assign imm_cur   = shifting_q ? imm_q : imm_fmt_val;
   assign o_imm_bit = imm_cur[0];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         shifting_q <= 1'b0;
      end else if (i_ibus_ack) begin
         shifting_q <= 1'b0;
      end else if (i_cnt_en) begin
         shifting_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= i_ibus_rdt;
      end else if (i_cnt_en) begin
         imm_q <= {imm_cur[XLEN-1], imm_cur[XLEN-1:1]};
      end
   end

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
   import serial_core_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_ibus_ack,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   output logic [REG_AW-1:0] o_rs1_addr,
   output logic [REG_AW-1:0] o_rs2_addr,
   output logic [REG_AW-1:0] o_rd_addr,
   output alu_op_t           o_alu_op,
   output logic              o_op_b_imm,
   output imm_fmt_t          o_imm_fmt,
   output rd_src_t           o_rd_src,
   output logic              o_jump,
   output logic              o_rd_we
);

   logic [6:0]        opcode_q;
   logic [2:0]        funct3_q;
   logic              funct7_b5_q;
   logic [REG_AW-1:0] rd_q;
   logic [REG_AW-1:0] rs1_q;
   logic [REG_AW-1:0] rs2_q;
   logic              reg_op;
   logic              imm_op;
   logic              lui_op;
   logic              jal_op;
   logic              funct3_ok;
   logic              kept;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode_q <= '0;
      end else if (i_ibus_ack) begin
         opcode_q <= i_ibus_rdt[6:0];
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         funct3_q    <= i_ibus_rdt[14:12];
         funct7_b5_q <= i_ibus_rdt[30];
         rd_q        <= i_ibus_rdt[11:7];
         rs1_q       <= i_ibus_rdt[19:15];
         rs2_q       <= i_ibus_rdt[24:20];
      end
   end

   assign reg_op = (opcode_q == OPC_REG);
   assign imm_op = (opcode_q == OPC_IMM);
   assign lui_op = (opcode_q == OPC_LUI);
   assign jal_op = (opcode_q == OPC_JAL);

   // Shifts and compares fall out here
   assign funct3_ok = (funct3_q == 3'b000) || (funct3_q == 3'b100) || (funct3_q[2:1] == 2'b11);
   assign kept      = ((reg_op || imm_op) && funct3_ok) || lui_op || jal_op;

   always_comb begin
      case (funct3_q)
         3'b100:  o_alu_op = ALU_XOR;
         3'b110:  o_alu_op = ALU_OR;
         3'b111:  o_alu_op = ALU_AND;
         default: o_alu_op = (reg_op && funct7_b5_q) ? ALU_SUB : ALU_ADD;
      endcase
   end

   assign o_op_b_imm = imm_op;
   assign o_imm_fmt  = jal_op ? IMM_J : (lui_op ? IMM_U : IMM_I);
   assign o_rd_src   = jal_op ? RD_LINK : (lui_op ? RD_IMM : RD_ALU);
   assign o_jump     = jal_op;
   assign o_rd_we    = kept && (rd_q != '0);
   assign o_rd_addr  = rd_q;
   assign o_rs1_addr = rs1_q;
   assign o_rs2_addr = rs2_q;

endmodule

// File: source/core_state.sv
`timescale 1ns/1ps

module core_state
   import serial_core_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_ibus_ack,
   input  logic             i_rd_we,
   output logic             o_ibus_cyc,
   output logic             o_cnt_en,
   output logic             o_cnt_done,
   output logic             o_rd_wen,
   output logic [CNT_W-1:0] o_cnt
);

   logic             exec_q;
   logic [CNT_W-1:0] cnt_q;
   logic             last_bit;

   assign last_bit = (cnt_q == CNT_W'(XLEN - 1));

   // Fetch while idle, then 32 execute cycles
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         exec_q <= 1'b0;
         cnt_q  <= '0;
      end else if (exec_q) begin
         cnt_q <= cnt_q + CNT_W'(1);
         if (last_bit) begin
            exec_q <= 1'b0;
         end
      end else if (i_ibus_ack) begin
         exec_q <= 1'b1;
         cnt_q  <= '0;
      end
   end

   assign o_ibus_cyc = !exec_q;
   assign o_cnt_en   = exec_q;
   assign o_cnt      = cnt_q;
   assign o_cnt_done = exec_q && last_bit;

   // Write strobe only in execute
   assign o_rd_wen   = exec_q && i_rd_we;

endmodule

// File: source/serial_core_pkg.sv
package serial_core_pkg;

   // Datapath width and number of execute cycles
   localparam int XLEN   = 32;
   localparam int CNT_W  = 5;
   localparam int REG_AW = 5;

   // Major opcodes of the supported instructions
   localparam logic [6:0] OPC_REG = 7'b0110011;
   localparam logic [6:0] OPC_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI = 7'b0110111;
   localparam logic [6:0] OPC_JAL = 7'b1101111;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_t;

   typedef enum logic [1:0] {
      IMM_I,
      IMM_U,
      IMM_J
   } imm_fmt_t;

   // Where each destination bit comes from
   typedef enum logic [1:0] {
      RD_ALU,
      RD_IMM,
      RD_LINK
   } rd_src_t;

endpackage
